// File: cpu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// 8-bit accumulator CPU shared definitions
// data and address widths, program depth, opcode numbering and the
// register-select codes used by IN and OUT
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package cpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int WORD_W     = 8;
  localparam int ADDR_W     = 4;
  localparam int PROG_DEPTH = 16;

  // one data byte or one instruction word
  typedef logic [WORD_W-1:0] word_t;

  // program memory address, also the program counter
  typedef logic [ADDR_W-1:0] addr_t;

  // operand field of an instruction, half a word
  typedef logic [WORD_W/2-1:0] nibble_t;

  ////////////////////////////////////////////////////////////////////////////
  // instruction set
  ////////////////////////////////////////////////////////////////////////////

  // upper nibble of the instruction word
  // codes 12 to 15 are unassigned and behave as NOP
  typedef enum logic [3:0] {
    NOP    = 4'd0,
    LDA_LO = 4'd1,
    LDA_HI = 4'd2,
    LDB_LO = 4'd3,
    LDB_HI = 4'd4,
    LDC_LO = 4'd5,
    LDC_HI = 4'd6,
    ADD    = 4'd7,
    SUB    = 4'd8,
    MUL    = 4'd9,
    OUT    = 4'd10,
    IN     = 4'd11
  } opcode_t;

  // operand values picking a register for IN and OUT
  // anything else turns those two into no-ops
  localparam nibble_t REG_SEL_A = 4'd0;
  localparam nibble_t REG_SEL_B = 4'd1;
  localparam nibble_t REG_SEL_C = 4'd2;

endpackage

`default_nettype wire

// File: cpu_program_ram.sv
////////////////////////////////////////////////////////////////////////////
// program memory
// 16 instruction words, one external write port, one registered read
// port feeding the execute core
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module cpu_program_ram (
  input  wire            clk,
  input  wire            rst_n,
  input  wire            wr_en,
  input  cpu_pkg::addr_t wr_addr,
  input  cpu_pkg::word_t wr_data,
  input  cpu_pkg::addr_t rd_addr,
  output cpu_pkg::word_t rd_data
);

  import cpu_pkg::*;

  // storage, every word a NOP after reset
  word_t mem [PROG_DEPTH];

  ////////////////////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < PROG_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////////////////////

  // one cycle of latency from rd_addr to rd_data
  // a write in the same cycle is seen on the following read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // a write with an unknown address would corrupt the whole program
  wr_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> !$isunknown(wr_addr)
  ) else $error("program write with unknown address %h", wr_addr);

endmodule

`default_nettype wire

// File: cpu_fetch.sv
////////////////////////////////////////////////////////////////////////////
// instruction fetch
// program counter stepping once per clock while run is high, plus the
// valid flag that marks the memory read data as a live instruction
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module cpu_fetch (
  input  wire            clk,
  input  wire            rst_n,
  input  wire            run,
  output cpu_pkg::addr_t rd_addr,
  output logic           instr_valid
);

  import cpu_pkg::*;

  addr_t pc;

  ////////////////////////////////////////////////////////////////////////////
  // program counter
  ////////////////////////////////////////////////////////////////////////////

  // 4-bit counter wraps 15 -> 0 on its own
  // holds its value while the CPU is stopped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (run) begin
      pc <= pc + 1'b1;
    end
  end

  // memory sees the counter directly
  assign rd_addr = pc;

  ////////////////////////////////////////////////////////////////////////////
  // instruction valid
  ////////////////////////////////////////////////////////////////////////////

  // the memory answers one cycle after the address, so run is
  // delayed by the same amount to line up with rd_data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= run;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // a valid instruction always comes from an address fetched while running
  valid_follows_run: assert property (
    @(posedge clk) disable iff (!rst_n)
    instr_valid |-> $past(run)
  ) else $error("instr_valid high without run in the previous cycle");

endmodule

`default_nettype wire

// File: cpu_execute.sv
////////////////////////////////////////////////////////////////////////////
// execute core
// decodes one instruction per cycle, keeps registers A, B and C, runs
// the add/sub/mul ALU into C and handles the IN and OUT byte paths
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module cpu_execute (
  input  wire            clk,
  input  wire            rst_n,
  input  cpu_pkg::word_t instr,
  input  wire            instr_valid,
  input  cpu_pkg::word_t in_data,
  output cpu_pkg::word_t out_data,
  output logic           out_valid
);

  import cpu_pkg::*;

  // instruction fields
  opcode_t opcode;
  nibble_t operand;

  // architectural registers
  word_t reg_a;
  word_t reg_b;
  word_t reg_c;

  // next-state values
  word_t a_next;
  word_t b_next;
  word_t c_next;

  // register picked by the operand for IN and OUT
  word_t sel_data;
  logic  sel_ok;

  // OUT with a legal operand in this cycle
  logic  out_fire;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  // codes 12..15 land outside the enum and fall to the default arm
  assign opcode  = opcode_t'(instr[7:4]);
  assign operand = instr[3:0];

  // register select shared by IN and OUT
  always_comb begin
    sel_ok   = 1'b1;
    sel_data = '0;
    case (operand)
      REG_SEL_A: sel_data = reg_a;
      REG_SEL_B: sel_data = reg_b;
      REG_SEL_C: sel_data = reg_c;
      default:   sel_ok   = 1'b0;
    endcase
  end

  assign out_fire = instr_valid && (opcode == OUT) && sel_ok;

  ////////////////////////////////////////////////////////////////////////////
  // next register values
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    a_next = reg_a;
    b_next = reg_b;
    c_next = reg_c;

    if (instr_valid) begin
      case (opcode)
        // nibble loads leave the other half alone
        LDA_LO: a_next = {reg_a[7:4], operand};
        LDA_HI: a_next = {operand, reg_a[3:0]};
        LDB_LO: b_next = {reg_b[7:4], operand};
        LDB_HI: b_next = {operand, reg_b[3:0]};
        LDC_LO: c_next = {reg_c[7:4], operand};
        LDC_HI: c_next = {operand, reg_c[3:0]};

        // ALU results truncate to 8 bits, so everything is modulo 256
        ADD: c_next = reg_a + reg_b;
        SUB: c_next = reg_a - reg_b;
        MUL: c_next = reg_a * reg_b;

        // external byte into the selected register
        IN: begin
          case (operand)
            REG_SEL_A: a_next = in_data;
            REG_SEL_B: b_next = in_data;
            REG_SEL_C: c_next = in_data;
            default: begin
              a_next = reg_a;
            end
          endcase
        end

        // NOP, OUT and unassigned codes keep all registers
        default: begin
          c_next = reg_c;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_c <= '0;
    end else begin
      reg_a <= a_next;
      reg_b <= b_next;
      reg_c <= c_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output path
  ////////////////////////////////////////////////////////////////////////////

  // out_data keeps the last value written by OUT
  // strobe is high for the single cycle after the OUT
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_data  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= out_fire;
      if (out_fire) begin
        out_data <= sel_data;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // strobe only after a valid OUT, carrying the register it selected
  out_after_valid_out: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(instr_valid) && ($past(instr[7:4]) == OUT) &&
                  (out_data == $past(sel_data))
  ) else $error("out_valid without a preceding OUT, data %h", out_data);

endmodule

`default_nettype wire

// File: cpu_top.sv
////////////////////////////////////////////////////////////////////////////
// 8-bit accumulator CPU top level
// fetch streams the 16-word program memory into the execute core,
// memory is loaded from outside while run is low
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module cpu_top (
  input  wire            clk,
  input  wire            rst_n,
  input  wire            run,
  input  wire            load_en,
  input  cpu_pkg::addr_t load_addr,
  input  cpu_pkg::word_t load_data,
  input  cpu_pkg::word_t in_data,
  output cpu_pkg::word_t out_data,
  output wire            out_valid
);

  import cpu_pkg::*;

  // fetch to memory
  addr_t rd_addr;

  // memory to execute, qualified by instr_valid
  word_t rd_data;
  logic  instr_valid;

  ////////////////////////////////////////////////////////////////////////////
  // instruction fetch
  ////////////////////////////////////////////////////////////////////////////

  cpu_fetch cpu_fetch_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .rd_addr     (rd_addr),
    .instr_valid (instr_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // program memory
  ////////////////////////////////////////////////////////////////////////////

  // external load port goes straight to the write side
  cpu_program_ram cpu_program_ram_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (load_en),
    .wr_addr (load_addr),
    .wr_data (load_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // execute core
  ////////////////////////////////////////////////////////////////////////////

  // no back-pressure, one instruction accepted per cycle
  cpu_execute cpu_execute_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (rd_data),
    .instr_valid (instr_valid),
    .in_data     (in_data),
    .out_data    (out_data),
    .out_valid   (out_valid)
  );

endmodule

`default_nettype wire

// File: cpu_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the 8-bit accumulator CPU
// loads a short program per table row, runs it and checks the OUT byte
// and strobe timing against values worked out from the instruction set
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module cpu_tb;

  import cpu_pkg::*;

  localparam int NUM_ROWS     = 16;
  localparam int NUM_FIXED    = 13;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CHECKS  = 8;

  // program layout: operation just before the OUT
  localparam int OP_ADDR      = 4;
  localparam int OUT_ADDR     = 5;

  // strobe follows the OUT by one cycle, then repeats once per program pass
  localparam int FIRST_PULSE  = OUT_ADDR + 1;
  localparam int LAST_PULSE   = FIRST_PULSE + PROG_DEPTH;
  localparam int STOP_CHECKS  = 20;
  localparam int RUN_STEPS    = LAST_PULSE + 1 + STOP_CHECKS;

  localparam int TIMEOUT_CYCLES = NUM_ROWS * 60 + 100;

  logic  clk;
  logic  rst_n;
  logic  run;
  logic  load_en;
  addr_t load_addr;
  word_t load_data;
  word_t in_data;
  word_t out_data;
  logic  out_valid;

  // stimulus table, one program per row
  opcode_t row_op  [NUM_ROWS];
  word_t   row_a   [NUM_ROWS];
  word_t   row_b   [NUM_ROWS];
  word_t   row_in  [NUM_ROWS];
  nibble_t row_sel [NUM_ROWS];
  word_t   row_exp [NUM_ROWS];

  int error_count;
  int test_count;
  int fail_count;
  int cycle_count;

  cpu_top cpu_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .in_data   (in_data),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t make_instr(input opcode_t op, input nibble_t operand);
    return {op, operand};
  endfunction

  // result of one row's program, modulo 256
  function automatic word_t expected_result(input opcode_t op, input word_t a,
                                            input word_t b, input word_t in_byte,
                                            input nibble_t sel);
    logic [15:0] full;
    full = 16'd0;
    case (op)
      ADD: full = {8'd0, a} + {8'd0, b};
      SUB: full = {8'd0, a} - {8'd0, b};
      MUL: full = {8'd0, a} * {8'd0, b};
      IN:  full = {8'd0, in_byte};
      default: begin
        // plain OUT rows: C only got its low nibble loaded
        if (sel == REG_SEL_A) full = {8'd0, a};
        else if (sel == REG_SEL_B) full = {8'd0, b};
        else full = {12'd0, b[7:4]};
      end
    endcase
    return full[7:0];
  endfunction

  function automatic string op_label(input opcode_t op);
    case (op)
      ADD:     return "ADD";
      SUB:     return "SUB";
      MUL:     return "MUL";
      IN:      return "IN";
      default: return "OUT";
    endcase
  endfunction

  task automatic wait_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic set_row(input int idx, input opcode_t op, input word_t a,
                         input word_t b, input word_t in_byte, input nibble_t sel,
                         input word_t exp);
    row_op[idx]  = op;
    row_a[idx]   = a;
    row_b[idx]   = b;
    row_in[idx]  = in_byte;
    row_sel[idx] = sel;
    row_exp[idx] = exp;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_table();
    logic [31:0] rng;
    opcode_t     op;
    int          i;
    // ALU rows, including overflow and going below zero
    set_row(0,  ADD, 8'h12, 8'h34, 8'hFF, REG_SEL_C, 8'h46);
    set_row(1,  ADD, 8'hF0, 8'h25, 8'hFF, REG_SEL_C, 8'h15);
    set_row(2,  SUB, 8'h50, 8'h20, 8'hFF, REG_SEL_C, 8'h30);
    set_row(3,  SUB, 8'h10, 8'h30, 8'hFF, REG_SEL_C, 8'hE0);
    set_row(4,  MUL, 8'h07, 8'h09, 8'hFF, REG_SEL_C, 8'h3F);
    set_row(5,  MUL, 8'h1F, 8'h23, 8'hFF, REG_SEL_C, 8'h3D);
    // external byte into each register
    set_row(6,  IN,  8'h11, 8'h22, 8'hA5, REG_SEL_A, 8'hA5);
    set_row(7,  IN,  8'h11, 8'h22, 8'h3C, REG_SEL_B, 8'h3C);
    set_row(8,  IN,  8'h11, 8'h22, 8'hC3, REG_SEL_C, 8'hC3);
    // nibble loads only
    set_row(9,  NOP, 8'h9E, 8'h00, 8'h55, REG_SEL_A, 8'h9E);
    set_row(10, NOP, 8'h00, 8'h6B, 8'h55, REG_SEL_B, 8'h6B);
    set_row(11, NOP, 8'h00, 8'hD4, 8'h55, REG_SEL_C, 8'h0D);
    // operand 3 selects nothing, so no strobe
    set_row(12, ADD, 8'h01, 8'h02, 8'hFF, 4'd3, 8'h00);

    rng = 32'd47212;
    for (i = NUM_FIXED; i < NUM_ROWS; i++) begin
      rng = xorshift32(rng);
      case (i % 3)
        0:       op = ADD;
        1:       op = SUB;
        default: op = MUL;
      endcase
      set_row(i, op, rng[7:0], rng[15:8], rng[23:16], REG_SEL_C,
              expected_result(op, rng[7:0], rng[15:8], rng[23:16], REG_SEL_C));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one table row: reset, load, run, stop
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_row(input int idx);
    word_t prog [PROG_DEPTH];
    logic  strobe_expected;
    logic  pulse_due;
    word_t held_data;
    int    errors_before;
    int    i;
    errors_before   = error_count;
    strobe_expected = (row_sel[idx] <= REG_SEL_C);

    for (i = 0; i < PROG_DEPTH; i++) begin
      prog[i] = make_instr(NOP, 4'd0);
    end
    // A high nibble first, B low nibble first, so each load must keep the other half
    prog[0] = make_instr(LDA_HI, row_a[idx][7:4]);
    prog[1] = make_instr(LDA_LO, row_a[idx][3:0]);
    prog[2] = make_instr(LDB_LO, row_b[idx][3:0]);
    prog[3] = make_instr(LDB_HI, row_b[idx][7:4]);
    case (row_op[idx])
      IN:      prog[OP_ADDR] = make_instr(IN, row_sel[idx]);
      NOP:     prog[OP_ADDR] = make_instr(LDC_LO, row_b[idx][7:4]);
      default: prog[OP_ADDR] = make_instr(row_op[idx], 4'd0);
    endcase
    prog[OUT_ADDR] = make_instr(OUT, row_sel[idx]);

    rst_n = 1'b0;
    wait_cycle();
    rst_n   = 1'b1;
    in_data = row_in[idx];

    // load with run low, counter sits at 0
    for (i = 0; i < PROG_DEPTH; i++) begin
      load_en   = 1'b1;
      load_addr = addr_t'(i);
      load_data = prog[i];
      wait_cycle();
    end
    load_en = 1'b0;
    run     = 1'b1;

    // step i samples the outputs just after the i-th edge with run high
    for (i = 0; i < RUN_STEPS; i++) begin
      wait_cycle();
      pulse_due = strobe_expected && (i == FIRST_PULSE || i == LAST_PULSE);
      if (strobe_expected && i >= FIRST_PULSE) begin
        held_data = row_exp[idx];
      end else begin
        held_data = 8'h00;
      end
      check_value("out_valid", {7'd0, out_valid}, {7'd0, pulse_due});
      check_value("out_data", out_data, held_data);
      if (i == LAST_PULSE) begin
        run = 1'b0;
      end
    end

    test_count++;
    if (error_count == errors_before) begin
      $display("test %0d %s a=%h b=%h in=%h sel=%0d: ok", idx, op_label(row_op[idx]),
               row_a[idx], row_b[idx], row_in[idx], row_sel[idx]);
    end else begin
      fail_count++;
      $display("test %0d %s a=%h b=%h in=%h sel=%0d: %0d mismatches", idx,
               op_label(row_op[idx]), row_a[idx], row_b[idx], row_in[idx],
               row_sel[idx], error_count - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int row;
    int errors_before;
    int i;
    rst_n       = 1'b0;
    run         = 1'b0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    in_data     = '0;
    error_count = 0;
    test_count  = 0;
    fail_count  = 0;
    cycle_count = 0;

    fill_table();

    repeat (RESET_CYCLES) wait_cycle();
    rst_n = 1'b1;

    // outputs stay quiet with run low
    errors_before = error_count;
    for (i = 0; i < IDLE_CHECKS; i++) begin
      wait_cycle();
      check_value("out_valid", {7'd0, out_valid}, 8'h00);
      check_value("out_data", out_data, 8'h00);
    end
    test_count++;
    if (error_count == errors_before) begin
      $display("test reset idle: ok");
    end else begin
      fail_count++;
      $display("test reset idle: %0d mismatches", error_count - errors_before);
    end

    for (row = 0; row < NUM_ROWS; row++) begin
      run_row(row);
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors", test_count,
             test_count - fail_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
cpu_pkg.sv
cpu_program_ram.sv
cpu_fetch.sv
cpu_execute.sv
cpu_top.sv
cpu_tb.sv
